// File: sources.f
+incdir+logic
logic/polar_pkg.sv
logic/llr_stage_array.sv
logic/sc_controller.sv
logic/frame_sequencer.sv
logic/polar_decoder.sv
sim/clock_gen.sv
sim/tb_polar_decoder.sv

// File: run.sh
#!/bin/sh
# Builds the decoder testbench with Verilator and runs it.
# The exit status is the simulator's, so a failed check fails the script.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_polar_decoder -Mdir obj_dir -f sources.f
./obj_dir/Vtb_polar_decoder

// File: sim/tb_polar_decoder.sv
`default_nettype none
// ------------------------------
// Directed tests with noiseless +/-100 LLRs, so decoding must be exact
// Pattern memory is refilled before each pattern is built
// ------------------------------
`include "polar_macros.svh"

module tb_polar_decoder;
    timeunit 1ns;
    timeprecision 100ps;
    import polar_pkg::*;

    typedef logic [`RADDR_W-1:0] addr_t;
    typedef logic [`WADDR_W-1:0] waddr_t;

    localparam int MEM_DEPTH    = 1 << `RADDR_W;
    localparam int RESULT_DEPTH = 1 << `WADDR_W;
    localparam int RUN_LIMIT    = 2000;
    localparam int REL_ORDER [`POLAR_N] = '{0, 1, 2, 4, 8, 3, 5, 6, 9, 10, 12, 7, 11, 13, 14, 15};

    wire                  clk;
    wire                  rst_n;
    logic                 module_en;
    logic [`RDATA_W-1:0]  rdata;
    logic [`RADDR_W-1:0]  raddr;
    logic [`WADDR_W-1:0]  waddr;
    msg_t                 wdata;
    logic                 wen;
    logic                 proc_done;

    // Pattern ROM and result memory
    logic [`RDATA_W-1:0]  mem [MEM_DEPTH];
    msg_t                 result_mem [RESULT_DEPTH];
    waddr_t               write_addrs [$];
    msg_t                 exp_words [$];
    int                   done_count;
    logic                 wen_prev;

    clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    polar_decoder UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .module_en (module_en),
        .rdata     (rdata),
        .raddr     (raddr),
        .waddr     (waddr),
        .wdata     (wdata),
        .wen       (wen),
        .proc_done (proc_done)
    );

    assign rdata = mem[raddr];

    // ------------------------------
    // Failure reporting and compares
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_msg(input string name, input msg_t got, input msg_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_waddr(input string name, input waddr_t got, input waddr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // Memory side of the write port, sampled where outputs are settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (wen) begin
                result_mem[waddr] = wdata;
                write_addrs.push_back(waddr);
            end
            if (proc_done) begin
                if (!wen_prev) begin
                    abort_run("proc_done came without a write in the cycle before");
                end
                done_count++;
            end
            wen_prev = wen;
        end
    end

    // ------------------------------
    // Reference encoder
    // ------------------------------
    function automatic msg_t info_mask(input int k);
        msg_t mask;
        mask = '0;
        for (int r = `POLAR_N - k; r < `POLAR_N; r++) begin
            mask[REL_ORDER[r]] = 1'b1;
        end
        return mask;
    endfunction

    function automatic msg_t low_mask(input int k);
        msg_t mask;
        mask = '0;
        for (int i = 0; i < k; i++) begin
            mask[i] = 1'b1;
        end
        return mask;
    endfunction

    function automatic msg_t encode(input msg_t msg, input int k);
        msg_t u;
        msg_t mask;
        int   j;
        u    = '0;
        mask = info_mask(k);
        j    = 0;
        for (int idx = 0; idx < `POLAR_N; idx++) begin
            if (mask[idx]) begin
                u[idx] = msg[j];
                j++;
            end
        end
        // Butterfly, each bit folds in its partner at distance h
        for (int h = 1; h < `POLAR_N; h = h * 2) begin
            for (int i = 0; i < `POLAR_N; i++) begin
                if ((i & h) == 0) begin
                    u[i] = u[i] ^ u[i + h];
                end
            end
        end
        return u;
    endfunction

    function automatic logic [`RDATA_W-1:0] llr_word(input msg_t code);
        logic [`RDATA_W-1:0] word;
        llr_t                v;
        word = '0;
        for (int i = 0; i < `POLAR_N; i++) begin
            v = code[i] ? llr_t'(-100) : llr_t'(100);
            word[i*`LLR_W +: `LLR_W] = v;
        end
        return word;
    endfunction

    // ------------------------------
    // Pattern building and running
    // ------------------------------
    task automatic begin_pattern();
        exp_words.delete();
        for (int a = 0; a < MEM_DEPTH; a++) begin
            mem[a] = {16{12'(a)}};
        end
    endtask

    task automatic add_packet(input int k, input msg_t msg);
        int                  p;
        msg_t                kept;
        logic [`RDATA_W-1:0] hdr;
        p    = exp_words.size();
        kept = msg & low_mask(k);
        hdr  = '0;
        hdr[`K_LSB +: `K_W] = (`K_W)'(k);
        mem[1 + 2*p] = hdr;
        mem[2 + 2*p] = llr_word(encode(kept, k));
        exp_words.push_back(kept);
    endtask

    task automatic run_pattern();
        int cycles;
        write_addrs.delete();
        done_count = 0;
        mem[0] = '0;
        mem[0][`PKT_CNT_W-1:0] = (`PKT_CNT_W)'(exp_words.size());
        @(negedge clk);
        check_addr("raddr before start", raddr, '0);
        module_en = 1'b1;
        @(negedge clk);
        module_en = 1'b0;
        cycles = 0;
        while (!proc_done && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!proc_done) begin
            abort_run("timed out waiting for proc_done");
        end
        // Room for FINISH to clear raddr and for a stray second pulse
        repeat (3) @(negedge clk);
        check_addr("raddr after finish", raddr, '0);
        check_bit("proc_done pulsed once", done_count == 1, 1'b1);
        check_bit("one write per packet", write_addrs.size() == exp_words.size(), 1'b1);
        foreach (exp_words[i]) begin
            check_waddr($sformatf("waddr of write %0d", i), write_addrs[i], waddr_t'(i));
            check_msg($sformatf("wdata at waddr %0d", i), result_mem[i], exp_words[i]);
        end
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic idle_after_reset();
        check_bit("wen", wen, 1'b0);
        check_bit("proc_done", proc_done, 1'b0);
        check_addr("raddr", raddr, '0);
    endtask

    task automatic full_rate_packet();
        begin_pattern();
        add_packet(16, msg_t'($urandom()));
        run_pattern();
    endtask

    task automatic half_rate_packet();
        begin_pattern();
        add_packet(8, msg_t'($urandom()));
        run_pattern();
    endtask

    task automatic three_packet_pattern();
        begin_pattern();
        add_packet(1, msg_t'($urandom()));
        add_packet(11, msg_t'($urandom()));
        add_packet(5, msg_t'($urandom()));
        run_pattern();
    endtask

    task automatic repeat_pattern();
        begin_pattern();
        add_packet(12, msg_t'($urandom()));
        add_packet(3, msg_t'($urandom()));
        run_pattern();
    endtask

    initial begin
        int wait_cycles;
        module_en  = 1'b0;
        wen_prev   = 1'b0;
        done_count = 0;
        void'($urandom(68914));
        begin_pattern();
        wait_cycles = 0;
        while (rst_n !== 1'b1 && wait_cycles < 20) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        @(negedge clk);
        idle_after_reset();
        full_rate_packet();
        half_rate_packet();
        three_packet_pattern();
        repeat_pattern();
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`default_nettype none
// ------------------------------
// 4 ns clock, reset low for the first two rising edges
// ------------------------------

module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Released on a falling edge, clear of the DUT's sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: logic/polar_decoder.sv
`default_nettype none
// ------------------------------
// Decoder top for N = 16 with one packet in flight
// rdata must follow raddr in the same cycle
// ------------------------------
`include "polar_macros.svh"

module polar_decoder (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  module_en,
    input  wire  [`RDATA_W-1:0]  rdata,
    output logic [`RADDR_W-1:0]  raddr,
    output logic [`WADDR_W-1:0]  waddr,
    output polar_pkg::msg_t      wdata,
    output logic                 wen,
    output logic                 proc_done
);
    import polar_pkg::*;

    // Sequencer to controller
    logic                   start;
    logic                   done;
    logic [`K_W-1:0]        k_value;
    llr_vec_t               channel_llr;
    msg_t                   message;

    // Controller to stage array
    logic                   load;
    logic [1:0]             stage_sel;
    pe_op_t                 op;
    logic [`POLAR_N/2-1:0]  partial_sums;
    stage_llr_t             leaf_llr [2];

    frame_sequencer u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .module_en   (module_en),
        .rdata       (rdata),
        .raddr       (raddr),
        .start       (start),
        .k_value     (k_value),
        .channel_llr (channel_llr),
        .done        (done),
        .message     (message),
        .waddr       (waddr),
        .wdata       (wdata),
        .wen         (wen),
        .proc_done   (proc_done)
    );

    sc_controller u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .k_value      (k_value),
        .channel_llr  (channel_llr),
        .leaf_llr     (leaf_llr),
        .load         (load),
        .stage_sel    (stage_sel),
        .op           (op),
        .partial_sums (partial_sums),
        .done         (done),
        .message      (message)
    );

    llr_stage_array u_array (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .channel_llr  (channel_llr),
        .stage_sel    (stage_sel),
        .op           (op),
        .partial_sums (partial_sums),
        .leaf_llr     (leaf_llr)
    );

endmodule

`default_nettype wire

// File: logic/frame_sequencer.sv
`default_nettype none
// ------------------------------
// Word 0 is the packet count, then a header and an LLR word per packet
// A count of 0 finishes at once without any write
// ------------------------------
`include "polar_macros.svh"

module frame_sequencer (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  module_en,
    input  wire  [`RDATA_W-1:0]  rdata,
    output logic [`RADDR_W-1:0]  raddr,
    output logic                 start,
    output logic [`K_W-1:0]      k_value,
    output polar_pkg::llr_vec_t  channel_llr,
    input  wire                  done,
    input  wire  polar_pkg::msg_t message,
    output logic [`WADDR_W-1:0]  waddr,
    output polar_pkg::msg_t      wdata,
    output logic                 wen,
    output logic                 proc_done
);
    import polar_pkg::*;

    seq_state_t             state;
    seq_state_t             next_state;
    logic [`PKT_CNT_W-1:0]  pkt_left;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (module_en) begin
                    next_state = READ_COUNT;
                end
            end
            READ_COUNT: begin
                next_state = (rdata[`PKT_CNT_W-1:0] == '0) ? FINISH : READ_HEADER;
            end
            READ_HEADER: next_state = READ_LLR;
            READ_LLR:    next_state = DECODE;
            DECODE: begin
                if (done) begin
                    next_state = WRITE;
                end
            end
            WRITE:   next_state = (pkt_left == '0) ? FINISH : READ_HEADER;
            default: next_state = IDLE;
        endcase
    end

    // ------------------------------
    // Control registers
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= IDLE;
            raddr     <= '0;
            waddr     <= '0;
            pkt_left  <= '0;
            start     <= 1'b0;
            wen       <= 1'b0;
            proc_done <= 1'b0;
        end else begin
            state     <= next_state;
            // LLR word lands this cycle, decoder kicks off next
            start     <= (state == READ_LLR);
            wen       <= (state == DECODE) && done;
            proc_done <= (next_state == FINISH);
            case (state)
                READ_COUNT: begin
                    pkt_left <= rdata[`PKT_CNT_W-1:0];
                    raddr    <= raddr + 1'b1;
                end
                READ_HEADER, READ_LLR: raddr <= raddr + 1'b1;
                DECODE: begin
                    if (done) begin
                        pkt_left <= pkt_left - 1'b1;
                    end
                end
                WRITE: waddr <= waddr + 1'b1;
                FINISH: begin
                    raddr <= '0;
                    waddr <= '0;
                end
                default: ;
            endcase
        end
    end

    // Packet payload
    always_ff @(posedge clk) begin
        if (state == READ_HEADER) begin
            k_value <= rdata[`K_LSB +: `K_W];
        end
        if (state == READ_LLR) begin
            for (int i = 0; i < `POLAR_N; i++) begin
                channel_llr[i] <= rdata[i*`LLR_W +: `LLR_W];
            end
        end
        if ((state == DECODE) && done) begin
            wdata <= message;
        end
    end

    // One write per decoded packet, right after the controller finishes
    assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> (state == WRITE) && $past(done))
        else $error("wen raised outside a packet write");

endmodule

`default_nettype wire

// File: logic/sc_controller.sv
`default_nettype none
// ------------------------------
// Serial SC schedule for N = 16 with leaves decided in pairs
// channel_llr must hold from start until load, k_value until done
// ------------------------------
`include "polar_macros.svh"

module sc_controller (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start,
    input  wire  [`K_W-1:0]             k_value,
    input  wire  polar_pkg::llr_vec_t   channel_llr,
    input  wire  polar_pkg::stage_llr_t leaf_llr [2],
    output logic                        load,
    output logic [1:0]                  stage_sel,
    output polar_pkg::pe_op_t           op,
    output logic [`POLAR_N/2-1:0]       partial_sums,
    output logic                        done,
    output polar_pkg::msg_t             message
);
    import polar_pkg::*;

    localparam int unsigned PAIRS = `POLAR_N / 2;

    logic                        busy;
    logic [1:0]                  stage_ptr;   // 0 means leaf decision
    logic [`POLAR_LOG_N-2:0]     pair_idx;    // bit L-1 marks right child at level L
    logic [`POLAR_LOG_N-2:0]     pair_inc;
    logic [1:0]                  next_ptr;
    logic [`POLAR_LOG_N:0]       msg_cnt;
    logic [`POLAR_LOG_N:0]       cnt_next;
    msg_t                        msg_next;
    logic                        leaf_step;
    logic                        frozen0;
    logic                        frozen1;
    logic                        u0;
    logic                        u1;
    stage_llr_t                  g_leaf;
    logic [1:0]                  enc1;
    logic [3:0]                  enc2;
    logic [7:0]                  enc3;
    logic [1:0]                  left1;
    logic [3:0]                  left2;
    logic [7:0]                  left3;
    logic [`POLAR_N*`LLR_W-1:0]  llr_flat;

    // Frozen when the rank of idx falls among the N-K least reliable
    function automatic logic is_frozen(input logic [`POLAR_LOG_N-1:0] idx,
                                       input logic [`K_W-1:0] k);
        int rank;
        rank = 0;
        for (int r = 0; r < `POLAR_N; r++) begin
            if (RELIABILITY[r] == idx) begin
                rank = r;
            end
        end
        return rank < (`POLAR_N - int'(k));
    endfunction

    // ------------------------------
    // Leaf pair decision
    // ------------------------------
    assign leaf_step = busy && !load && (stage_ptr == 2'd0);
    assign frozen0   = is_frozen({pair_idx, 1'b0}, k_value);
    assign frozen1   = is_frozen({pair_idx, 1'b1}, k_value);

    // Sign of f for the even bit
    assign u0 = !frozen0 && (leaf_llr[0] != 0) && (leaf_llr[1] != 0) &&
                ((leaf_llr[0] < 0) ^ (leaf_llr[1] < 0));
    assign g_leaf = u0 ? (leaf_llr[1] - leaf_llr[0]) : (leaf_llr[1] + leaf_llr[0]);
    assign u1 = !frozen1 && (g_leaf < 0);

    // Re-encoded partial sums, left half XOR right half
    assign enc1 = {u1, u0 ^ u1};
    assign enc2 = {enc1, left1 ^ enc1};
    assign enc3 = {enc2, left2 ^ enc2};

    always_comb begin
        msg_next = message;
        cnt_next = msg_cnt;
        if (!frozen0) begin
            msg_next[cnt_next[`POLAR_LOG_N-1:0]] = u0;
            cnt_next = cnt_next + 1'b1;
        end
        if (!frozen1) begin
            msg_next[cnt_next[`POLAR_LOG_N-1:0]] = u1;
            cnt_next = cnt_next + 1'b1;
        end
    end

    // Next pair restarts at the level of its lowest set bit
    assign pair_inc = pair_idx + 1'b1;
    assign next_ptr = pair_inc[0] ? 2'd1 : (pair_inc[1] ? 2'd2 : 2'd3);

    // ------------------------------
    // Stage array commands
    // ------------------------------
    assign stage_sel = (busy && !load) ? stage_ptr : 2'd0;

    always_comb begin
        op           = PE_F;
        partial_sums = '0;
        case (stage_sel)
            2'd1: begin
                op                = pair_idx[0] ? PE_G : PE_F;
                partial_sums[1:0] = left1;
            end
            2'd2: begin
                op                = pair_idx[1] ? PE_G : PE_F;
                partial_sums[3:0] = left2;
            end
            2'd3: begin
                op           = pair_idx[2] ? PE_G : PE_F;
                partial_sums = left3;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            stage_ptr <= '0;
            pair_idx  <= '0;
            msg_cnt   <= '0;
            load      <= 1'b0;
            done      <= 1'b0;
        end else begin
            load <= start;
            done <= 1'b0;
            if (start) begin
                busy      <= 1'b1;
                stage_ptr <= 2'd3;
                pair_idx  <= '0;
                msg_cnt   <= '0;
            end else if (busy && !load) begin
                if (stage_ptr != 2'd0) begin
                    stage_ptr <= stage_ptr - 1'b1;
                end else begin
                    msg_cnt <= cnt_next;
                    if (pair_idx == (`POLAR_LOG_N-1)'(PAIRS - 1)) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end else begin
                        pair_idx  <= pair_inc;
                        stage_ptr <= next_ptr;
                    end
                end
            end
        end
    end

    // Message and saved left-child partial sums
    always_ff @(posedge clk) begin
        if (start) begin
            message <= '0;
        end else if (leaf_step) begin
            message <= msg_next;
            if (!pair_idx[0]) begin
                left1 <= enc1;
            end else if (!pair_idx[1]) begin
                left2 <= enc2;
            end else if (!pair_idx[2]) begin
                left3 <= enc3;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `POLAR_N; i++) begin
            llr_flat[i*`LLR_W +: `LLR_W] = channel_llr[i];
        end
    end

    // ------------------------------
    // Handshake checks
    // ------------------------------
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !busy && !done)
        else $error("start during an active decode");

    assert property (@(posedge clk) disable iff (!rst_n)
        load |-> $stable(llr_flat))
        else $error("channel LLRs changed between start and load");

endmodule

`default_nettype wire

// File: logic/llr_stage_array.sv
`default_nettype none
// ------------------------------
// Eight shared f/g elements over 16, 8, 4 and 2 entry buffers
// stage_sel 3..1 writes the 8, 4 or 2 entry buffer, 0 holds all
// ------------------------------
`include "polar_macros.svh"

module llr_stage_array (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          load,
    input  wire  polar_pkg::llr_vec_t    channel_llr,
    input  wire  [1:0]                   stage_sel,
    input  wire  polar_pkg::pe_op_t      op,
    input  wire  [`POLAR_N/2-1:0]        partial_sums,
    output polar_pkg::stage_llr_t        leaf_llr [2]
);
    import polar_pkg::*;

    localparam int unsigned NUM_PE = `POLAR_N / 2;

    llr_t        chan_q [`POLAR_N];
    stage_llr_t  buf8_q [NUM_PE];
    stage_llr_t  buf4_q [NUM_PE/2];
    stage_llr_t  buf2_q [NUM_PE/4];
    stage_llr_t  pe_a   [NUM_PE];
    stage_llr_t  pe_b   [NUM_PE];
    stage_llr_t  pe_out [NUM_PE];

    // Min-sum f, or g with the partial sum choosing add or subtract
    function automatic stage_llr_t pe_calc(input pe_op_t f_op,
                                           input stage_llr_t a,
                                           input stage_llr_t b,
                                           input logic u);
        stage_llr_t mag_a;
        stage_llr_t mag_b;
        stage_llr_t mag_min;
        mag_a   = (a < 0) ? -a : a;
        mag_b   = (b < 0) ? -b : b;
        mag_min = (mag_a < mag_b) ? mag_a : mag_b;
        if (f_op == PE_G) begin
            return u ? (b - a) : (b + a);
        end
        return ((a < 0) ^ (b < 0)) ? -mag_min : mag_min;
    endfunction

    // ------------------------------
    // Operand select, entry i against i + half
    // ------------------------------
    always_comb begin
        for (int i = 0; i < NUM_PE; i++) begin
            pe_a[i] = '0;
            pe_b[i] = '0;
        end
        case (stage_sel)
            2'd3: begin
                for (int i = 0; i < NUM_PE; i++) begin
                    pe_a[i] = chan_q[i];
                    pe_b[i] = chan_q[i + NUM_PE];
                end
            end
            2'd2: begin
                for (int i = 0; i < NUM_PE/2; i++) begin
                    pe_a[i] = buf8_q[i];
                    pe_b[i] = buf8_q[i + NUM_PE/2];
                end
            end
            2'd1: begin
                for (int i = 0; i < NUM_PE/4; i++) begin
                    pe_a[i] = buf4_q[i];
                    pe_b[i] = buf4_q[i + NUM_PE/4];
                end
            end
            default: ;
        endcase
        for (int i = 0; i < NUM_PE; i++) begin
            pe_out[i] = pe_calc(op, pe_a[i], pe_b[i], partial_sums[i]);
        end
    end

    // Results land in the next smaller buffer
    always_ff @(posedge clk) begin
        if (load) begin
            chan_q <= channel_llr;
        end
        case (stage_sel)
            2'd3: begin
                for (int i = 0; i < NUM_PE; i++) begin
                    buf8_q[i] <= pe_out[i];
                end
            end
            2'd2: begin
                for (int i = 0; i < NUM_PE/2; i++) begin
                    buf4_q[i] <= pe_out[i];
                end
            end
            2'd1: begin
                for (int i = 0; i < NUM_PE/4; i++) begin
                    buf2_q[i] <= pe_out[i];
                end
            end
            default: ;
        endcase
    end

    assign leaf_llr = buf2_q;

    // Stage select known, and idle while the channel word is captured
    assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(stage_sel) && (!load || (stage_sel == 2'd0)))
        else $error("stage_sel out of range or active during load");

endmodule

`default_nettype wire

// File: logic/polar_pkg.sv
`default_nettype none
// ------------------------------
// Types shared by the N = 16 decoder
// Stage LLRs carry 4 guard bits so g sums cannot wrap
// ------------------------------
`include "polar_macros.svh"

package polar_pkg;

    // Pattern sequencer states
    typedef enum logic [2:0] {
        IDLE,
        READ_COUNT,
        READ_HEADER,
        READ_LLR,
        DECODE,
        WRITE,
        FINISH
    } seq_state_t;

    // Processing element opcode
    typedef enum logic {
        PE_F,   // min-sum
        PE_G    // add or subtract by partial sum
    } pe_op_t;

    typedef logic signed [`LLR_W-1:0] llr_t;
    typedef logic signed [`LLR_W+`POLAR_LOG_N-1:0] stage_llr_t;

    // All channel LLRs of one packet, entry i from rdata bits [12i+11:12i]
    typedef llr_t llr_vec_t [`POLAR_N];

    typedef logic [`POLAR_N-1:0] msg_t;

    // ------------------------------
    // Bit indices sorted from least to most reliable
    // ------------------------------
    localparam logic [`POLAR_LOG_N-1:0] RELIABILITY [`POLAR_N] = '{
        0, 1, 2, 4,
        8, 3, 5, 6,
        9, 10, 12, 7,
        11, 13, 14, 15
    };

endpackage

`default_nettype wire

// File: logic/polar_macros.svh
// ------------------------------
// Single code length build with N fixed at 16
// The N field of the header word is never decoded
// ------------------------------
`ifndef POLAR_MACROS_SVH
`define POLAR_MACROS_SVH

// Code geometry
`define POLAR_N      16
`define POLAR_LOG_N  4

// Channel LLR width
`define LLR_W        12

// Pattern and result memory ports
`define RDATA_W      192
`define RADDR_W      11
`define WADDR_W      6

// Fields of the count and header words
`define PKT_CNT_W    7
`define K_LSB        10
`define K_W          8

`endif
